/* src/dcache_settings.svh */
/*
 * widths and sizes of the two-way write-back data cache
 * one 64-bit word per line, so the offset only selects bytes
 * tag + index + offset must add up to the address width
 */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and data
`define DCACHE_ADDR_W   64
`define DCACHE_DATA_W   64
`define DCACHE_MASK_W   8

// address split
`define DCACHE_OFFSET_W 3
`define DCACHE_INDEX_W  6
`define DCACHE_TAG_W    55

// organisation
`define DCACHE_SETS     64
`define DCACHE_WAYS     2
`define DCACHE_AGE_W    3

`endif

/* src/dcache_pkg.sv */
/*
 * shared types of the data cache
 * the address is one word read either raw or as tag, index and offset
 */
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } addr_u;

    typedef struct packed {
        logic                      rd;
        logic                      wr;
        addr_u                     addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
        logic [`DCACHE_MASK_W-1:0] mask;
    } cpu_req_t;

    typedef struct packed {
        logic                      done;
        logic [`DCACHE_DATA_W-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                      rd;
        logic                      wr;
        logic [`DCACHE_ADDR_W-1:0] addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0] tag;
    } line_state_t;

    // array update command, spare bits kept at zero
    typedef struct packed {
        logic       tag_wr;
        logic       set_dirty;
        logic       clr_dirty;
        logic       touch;
        way_t       way;
        logic [2:0] spare;
    } fill_cmd_t;

endpackage

/* src/dcache_tag_array.sv */
/*
 * tag, valid and dirty bits for every way and set
 * reads are registered, a write shows up one read later
 * only valid and dirty are cleared by reset
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [`DCACHE_INDEX_W-1:0]            index_i,
    input  logic [`DCACHE_TAG_W-1:0]              tag_i,
    input  fill_cmd_t                             fill_i,
    output logic                                  hit_o,
    output way_t                                  hit_way_o,
    output line_state_t [`DCACHE_WAYS-1:0]        state_o
);

    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_r;
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] dirty_r;
    logic [`DCACHE_TAG_W-1:0]                  tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0]                   valid_rd;
    logic [`DCACHE_WAYS-1:0]                   dirty_rd;
    logic [`DCACHE_TAG_W-1:0]                  tag_rd [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0]                   hit_vec;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_r  <= '0;
            dirty_r  <= '0;
            valid_rd <= '0;
            dirty_rd <= '0;
        end else begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_rd[w] <= valid_r[w][index_i];
                dirty_rd[w] <= dirty_r[w][index_i];
            end
            if (fill_i.tag_wr)
                valid_r[fill_i.way][index_i] <= 1'b1;
            if (fill_i.set_dirty)
                dirty_r[fill_i.way][index_i] <= 1'b1;
            else if (fill_i.clr_dirty)
                dirty_r[fill_i.way][index_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
            tag_rd[w] <= tag_mem[w][index_i];
        if (fill_i.tag_wr)
            tag_mem[fill_i.way][index_i] <= tag_i;
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            state_o[w] = '{valid: valid_rd[w], dirty: dirty_rd[w], tag: tag_rd[w]};
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == tag_i);
        end
    end

    assign hit_o     = |hit_vec;
    assign hit_way_o = hit_vec[1];

    // a line never lives in both ways of a set
    assert property (@(posedge clk) disable iff (!rst) hit_vec !== 2'b11);

endmodule

/* src/dcache_data_array.sv */
/*
 * one data word per set and way, byte write enables
 * both ways are read every cycle, data one cycle after the index
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic                                          clk,
    input  logic [`DCACHE_INDEX_W-1:0]                    index_i,
    input  logic                                          wr_en_i,
    input  way_t                                          wr_way_i,
    input  logic [`DCACHE_DATA_W-1:0]                     wdata_i,
    input  logic [`DCACHE_MASK_W-1:0]                     mask_i,
    output logic [`DCACHE_WAYS-1:0][`DCACHE_DATA_W-1:0]   rdata_o
);

    logic [`DCACHE_DATA_W-1:0] mem [`DCACHE_WAYS][`DCACHE_SETS];

    // read before write on the same edge
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
            rdata_o[w] <= mem[w][index_i];
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `DCACHE_MASK_W; b++) begin
                if (mask_i[b])
                    mem[wr_way_i][index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

/* src/dcache_replace.sv */
/*
 * per-set age counters, one per way, saturating at the top value
 * a touch clears the touched way and ages the others
 * victim is the first invalid way, else the oldest, way 0 on a tie
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_replace
    import dcache_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`DCACHE_INDEX_W-1:0]    index_i,
    input  logic                          touch_i,
    input  way_t                          touch_way_i,
    input  logic [`DCACHE_WAYS-1:0]       valid_i,
    output way_t                          victim_way_o
);

    logic [`DCACHE_AGE_W-1:0] age [`DCACHE_WAYS][`DCACHE_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
                for (int s = 0; s < `DCACHE_SETS; s++)
                    age[w][s] <= '0;
        end else if (touch_i) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (way_t'(w) == touch_way_i)
                    age[w][index_i] <= '0;
                else if (age[w][index_i] != '1)
                    age[w][index_i] <= age[w][index_i] + 1'b1;
            end
        end
    end

    always_comb begin
        if (!valid_i[0])
            victim_way_o = 1'b0;
        else if (!valid_i[1])
            victim_way_o = 1'b1;
        else if (age[1][index_i] > age[0][index_i])
            victim_way_o = 1'b1;
        else
            victim_way_o = 1'b0;
    end

endmodule

/* src/dcache_ctrl.sv */
/*
 * single request controller, one core access in flight
 * hit: lookup then respond; miss: optional write-back, refill, update, respond
 * core holds its request until done, memory request held until ok
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst,
    input  cpu_req_t                                      cpu_req_i,
    output cpu_rsp_t                                      cpu_rsp_o,
    output mem_req_t                                      mem_req_o,
    input  logic                                          mem_ok_i,
    input  logic [`DCACHE_DATA_W-1:0]                     mem_rdata_i,
    input  logic                                          hit_i,
    input  way_t                                          hit_way_i,
    input  line_state_t [`DCACHE_WAYS-1:0]                state_i,
    input  way_t                                          victim_way_i,
    input  logic [`DCACHE_WAYS-1:0][`DCACHE_DATA_W-1:0]   way_data_i,
    output logic [`DCACHE_INDEX_W-1:0]                    index_o,
    output logic [`DCACHE_TAG_W-1:0]                      tag_o,
    output fill_cmd_t                                     fill_o,
    output logic                                          dwr_en_o,
    output way_t                                          dwr_way_o,
    output logic [`DCACHE_DATA_W-1:0]                     dwdata_o,
    output logic [`DCACHE_MASK_W-1:0]                     dmask_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WBACK,
        S_REFILL,
        S_UPDATE,
        S_RESPOND
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    way_t                      way_q;
    logic [`DCACHE_DATA_W-1:0] line_q;
    logic [`DCACHE_DATA_W-1:0] merged;
    mem_req_t                  mem_req_q;
    addr_u                     fill_addr;
    addr_u                     wb_addr;
    logic                      victim_dirty;

    // request held stable, so the arrays follow it directly
    assign index_o = cpu_req_i.addr.f.index;
    assign tag_o   = cpu_req_i.addr.f.tag;

    assign victim_dirty = state_i[victim_way_i].valid && state_i[victim_way_i].dirty;

    always_comb begin
        fill_addr          = cpu_req_i.addr;
        fill_addr.f.offset = '0;
        wb_addr.f.tag      = state_i[victim_way_i].tag;
        wb_addr.f.index    = cpu_req_i.addr.f.index;
        wb_addr.f.offset   = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (cpu_req_i.rd || cpu_req_i.wr) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (hit_i)
                    state_d = S_RESPOND;
                else if (victim_dirty)
                    state_d = S_WBACK;
                else
                    state_d = S_REFILL;
            end
            S_WBACK:   if (mem_ok_i) state_d = S_REFILL;
            S_REFILL:  if (mem_ok_i) state_d = S_UPDATE;
            S_UPDATE:  state_d = S_RESPOND;
            S_RESPOND: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= S_IDLE;
            mem_req_q <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                S_LOOKUP: begin
                    if (!hit_i && victim_dirty)
                        mem_req_q <= '{rd: 1'b0, wr: 1'b1, addr: wb_addr.raw,
                                       wdata: way_data_i[victim_way_i]};
                    else if (!hit_i)
                        mem_req_q <= '{rd: 1'b1, wr: 1'b0, addr: fill_addr.raw, wdata: '0};
                end
                S_WBACK: begin
                    if (mem_ok_i)
                        mem_req_q <= '{rd: 1'b1, wr: 1'b0, addr: fill_addr.raw, wdata: '0};
                end
                S_REFILL: begin
                    if (mem_ok_i)
                        mem_req_q <= '0;
                end
                default: ;
            endcase
        end
    end

    // hit word or refill word, later returned to the core
    always_ff @(posedge clk) begin
        if (state_q == S_LOOKUP) begin
            way_q  <= hit_i ? hit_way_i : victim_way_i;
            line_q <= way_data_i[hit_way_i];
        end else if (state_q == S_REFILL && mem_ok_i) begin
            line_q <= mem_rdata_i;
        end
    end

    always_comb begin
        for (int b = 0; b < `DCACHE_MASK_W; b++)
            merged[b*8 +: 8] = (cpu_req_i.wr && cpu_req_i.mask[b]) ?
                               cpu_req_i.wdata[b*8 +: 8] : line_q[b*8 +: 8];
    end

    always_comb begin
        fill_o    = '0;
        dwr_en_o  = 1'b0;
        dwr_way_o = way_q;
        dwdata_o  = merged;
        dmask_o   = '1;
        if (state_q == S_LOOKUP && hit_i) begin
            fill_o.touch     = 1'b1;
            fill_o.way       = hit_way_i;
            fill_o.set_dirty = cpu_req_i.wr;
            dwr_en_o         = cpu_req_i.wr;
            dwr_way_o        = hit_way_i;
            dwdata_o         = cpu_req_i.wdata;
            dmask_o          = cpu_req_i.mask;
        end else if (state_q == S_UPDATE) begin
            fill_o.tag_wr    = 1'b1;
            fill_o.touch     = 1'b1;
            fill_o.way       = way_q;
            fill_o.set_dirty = cpu_req_i.wr;
            fill_o.clr_dirty = !cpu_req_i.wr;
            dwr_en_o         = 1'b1;
        end
    end

    assign mem_req_o       = mem_req_q;
    assign cpu_rsp_o.done  = (state_q == S_RESPOND);
    assign cpu_rsp_o.rdata = (cpu_rsp_o.done && cpu_req_i.rd) ? line_q : '0;

    // memory sees the same request until it answers
    assert property (@(posedge clk) disable iff (!rst)
        (mem_req_o.rd || mem_req_o.wr) && !mem_ok_i |=> $stable(mem_req_o));

    assert property (@(posedge clk) disable iff (!rst)
        cpu_rsp_o.done |=> !cpu_rsp_o.done);

endmodule

/* src/dcache_top.sv */
/*
 * two-way write-back data cache, 64 sets of one 64-bit word
 * core request held until done, memory request held until ok
 * one access in flight, no pipelining
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_req_t                  cpu_req_i,
    output cpu_rsp_t                  cpu_rsp_o,
    output mem_req_t                  mem_req_o,
    input  logic                      mem_ok_i,
    input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i
);

    logic [`DCACHE_INDEX_W-1:0]                  index;
    logic [`DCACHE_TAG_W-1:0]                    tag;
    fill_cmd_t                                   fill;
    logic                                        hit;
    way_t                                        hit_way;
    line_state_t [`DCACHE_WAYS-1:0]              line_state;
    logic [`DCACHE_WAYS-1:0]                     way_valid;
    way_t                                        victim_way;
    logic [`DCACHE_WAYS-1:0][`DCACHE_DATA_W-1:0] way_data;
    logic                                        dwr_en;
    way_t                                        dwr_way;
    logic [`DCACHE_DATA_W-1:0]                   dwdata;
    logic [`DCACHE_MASK_W-1:0]                   dmask;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
            way_valid[w] = line_state[w].valid;
    end

    dcache_ctrl i_dcache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_rsp_o    (cpu_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_ok_i     (mem_ok_i),
        .mem_rdata_i  (mem_rdata_i),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .state_i      (line_state),
        .victim_way_i (victim_way),
        .way_data_i   (way_data),
        .index_o      (index),
        .tag_o        (tag),
        .fill_o       (fill),
        .dwr_en_o     (dwr_en),
        .dwr_way_o    (dwr_way),
        .dwdata_o     (dwdata),
        .dmask_o      (dmask)
    );

    dcache_tag_array i_dcache_tag_array (
        .clk       (clk),
        .rst       (rst),
        .index_i   (index),
        .tag_i     (tag),
        .fill_i    (fill),
        .hit_o     (hit),
        .hit_way_o (hit_way),
        .state_o   (line_state)
    );

    dcache_data_array i_dcache_data_array (
        .clk      (clk),
        .index_i  (index),
        .wr_en_i  (dwr_en),
        .wr_way_i (dwr_way),
        .wdata_i  (dwdata),
        .mask_i   (dmask),
        .rdata_o  (way_data)
    );

    // age update rides on the array command
    dcache_replace i_dcache_replace (
        .clk          (clk),
        .rst          (rst),
        .index_i      (index),
        .touch_i      (fill.touch),
        .touch_way_i  (fill.way),
        .valid_i      (way_valid),
        .victim_way_o (victim_way)
    );

endmodule

/* verification/dcache_checker.sv */
/*
 * compares DUT responses with the expectations of the running test
 * ports are sampled on the falling edge, where they are stable
 * a request counts as accepted at the first rising edge after it appears
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_checker
    import dcache_pkg::*;
(
    input logic     clk,
    input cpu_rsp_t cpu_rsp_i,
    input mem_req_t mem_req_i,
    input logic     mem_ok_i
);

    logic                      active = 1'b0;
    logic                      exp_wr;
    logic                      exp_miss;
    logic                      exp_wb;
    logic [`DCACHE_ADDR_W-1:0] exp_addr;
    logic [`DCACHE_ADDR_W-1:0] exp_wb_addr;
    logic [`DCACHE_DATA_W-1:0] exp_rdata;
    logic [`DCACHE_DATA_W-1:0] exp_wb_data;
    int                        cur_id = 0;
    int                        cycles;
    int                        latency;
    int                        done_cnt;
    int                        reads;
    int                        writes;
    int                        test_errs = 0;
    int                        tests_run = 0;
    int                        tests_clean = 0;
    int                        total_errs = 0;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("Fail %s expected %h got %h in test %0d", name, exp, got, cur_id);
        test_errs++;
        total_errs++;
    endtask

    task automatic report_problem(input string msg);
        if (active)
            $display("test %0d: %s", cur_id, msg);
        else
            $display("between tests: %s", msg);
        test_errs++;
        total_errs++;
    endtask

    task automatic start_test(input int id, input logic wr, input logic [63:0] addr,
                              input logic [63:0] rdata, input logic miss, input logic wb,
                              input logic [63:0] wb_addr, input logic [63:0] wb_data);
        cur_id      = id;
        exp_wr      = wr;
        exp_addr    = addr;
        exp_rdata   = rdata;
        exp_miss    = miss;
        exp_wb      = wb;
        exp_wb_addr = wb_addr;
        exp_wb_data = wb_data;
        // first falling edge comes before the accepting edge
        cycles      = -1;
        latency     = 0;
        done_cnt    = 0;
        reads       = 0;
        writes      = 0;
        test_errs   = 0;
        active      = 1'b1;
    endtask

    // one memory transfer completes at the next rising edge
    task automatic check_mem_beat();
        logic [`DCACHE_ADDR_W-1:0] aligned;
        aligned = {exp_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
        if (mem_req_i.wr === 1'b1) begin
            writes++;
            if (!exp_wb) begin
                report_problem("memory write when no write-back was due");
            end else begin
                if (mem_req_i.addr !== exp_wb_addr)
                    report_mismatch("mem_req_o.addr", exp_wb_addr, mem_req_i.addr);
                if (mem_req_i.wdata !== exp_wb_data)
                    report_mismatch("mem_req_o.wdata", exp_wb_data, mem_req_i.wdata);
            end
        end else if (mem_req_i.rd === 1'b1) begin
            reads++;
            if (!exp_miss)
                report_problem("memory read on an access that should hit");
            else if (exp_wb && writes == 0)
                report_problem("refill read came before the write-back");
            if (exp_miss && mem_req_i.addr !== aligned)
                report_mismatch("mem_req_o.addr", aligned, mem_req_i.addr);
        end
    endtask

    always @(negedge clk) begin
        if (!active) begin
            if (cpu_rsp_i.done !== 1'b0)
                report_problem("done raised with no request pending");
            if (mem_req_i.rd !== 1'b0 || mem_req_i.wr !== 1'b0)
                report_problem("memory request raised with no request pending");
        end else begin
            cycles++;
            if (cpu_rsp_i.done === 1'b1) begin
                done_cnt++;
                latency = cycles;
                if (cpu_rsp_i.rdata !== exp_rdata)
                    report_mismatch("cpu_rsp_o.rdata", exp_rdata, cpu_rsp_i.rdata);
            end
            if (mem_ok_i === 1'b1)
                check_mem_beat();
        end
    end

    task automatic finish_test();
        if (done_cnt != 1)
            report_problem($sformatf("done seen %0d times instead of once", done_cnt));
        if (reads != int'(exp_miss))
            report_problem($sformatf("%0d memory reads, expected %0d", reads, exp_miss));
        if (writes != int'(exp_wb))
            report_problem($sformatf("%0d memory writes, expected %0d", writes, exp_wb));
        if (!exp_miss && done_cnt == 1 && latency != 2)
            report_problem($sformatf("hit answered after %0d cycles instead of 2", latency));
        $display("test %0d %s %h: %s", cur_id, exp_wr ? "store" : "load", exp_addr,
                 test_errs == 0 ? "pass" : "fail");
        tests_run++;
        if (test_errs == 0)
            tests_clean++;
        active = 1'b0;
    endtask

    task automatic print_summary(output int errors);
        $display("summary: %0d run, %0d clean, %0d check errors",
                 tests_run, tests_clean, total_errs);
        errors = total_errs;
    endtask

endmodule

/* verification/dcache_tb.sv */
/*
 * runs a table of loads and stores through the cache, all on set index 5
 * memory answers 1 to 4 cycles after a request, delay drawn from a fixed seed
 * unwritten memory words read back as their address XOR a fixed pattern
 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam logic [63:0] mem_pattern  = 64'h5a5a_0000_0000_0000;
    localparam int          done_timeout = 40;

    typedef struct packed {
        logic        wr;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  mask;
        logic [63:0] rdata;
        logic        miss;
        logic        wb;
        logic [63:0] wb_addr;
        logic [63:0] wb_data;
    } row_t;

    // starts low without an edge, so nothing fires at time zero
    logic                      clk = 1'b0;
    logic                      rst;
    cpu_req_t                  cpu_req;
    cpu_rsp_t                  cpu_rsp;
    mem_req_t                  mem_req;
    logic                      mem_ok;
    logic [`DCACHE_DATA_W-1:0] mem_rdata;
    logic [63:0]               mem_model [logic [63:0]];
    logic                      mem_busy;
    int                        mem_wait;
    integer                    seed;
    row_t                      rows [$];
    logic                      timed_out;

    dcache_top i_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req),
        .cpu_rsp_o   (cpu_rsp),
        .mem_req_o   (mem_req),
        .mem_ok_i    (mem_ok),
        .mem_rdata_i (mem_rdata)
    );

    dcache_checker i_dcache_checker (
        .clk       (clk),
        .cpu_rsp_i (cpu_rsp),
        .mem_req_i (mem_req),
        .mem_ok_i  (mem_ok)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        if (mem_model.exists(addr))
            return mem_model[addr];
        return addr ^ mem_pattern;
    endfunction

    // ok is high for one cycle, the request is seen again only after it
    always @(posedge clk) begin
        #5;
        mem_ok = 1'b0;
        if (rst && !mem_busy && (mem_req.rd || mem_req.wr)) begin
            mem_busy = 1'b1;
            mem_wait = $unsigned($random(seed)) % 4;
        end
        if (mem_busy) begin
            if (mem_wait == 0) begin
                if (mem_req.wr)
                    mem_model[mem_req.addr] = mem_req.wdata;
                else
                    mem_rdata = read_word(mem_req.addr);
                mem_ok   = 1'b1;
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    task automatic add_row(input logic wr, input logic [63:0] addr, input logic [63:0] wdata,
                           input logic [7:0] mask, input logic [63:0] rdata, input logic miss,
                           input logic wb, input logic [63:0] wb_addr,
                           input logic [63:0] wb_data);
        row_t r;
        r = {wr, addr, wdata, mask, rdata, miss, wb, wb_addr, wb_data};
        rows.push_back(r);
    endtask

    task automatic fill_table();
        // wr, addr, wdata, mask, load data, miss, write-back, wb addr, wb data
        add_row(0, 64'h102c, 0, 8'h00, 64'h5a5a_0000_0000_1028, 1, 0, 0, 0);
        add_row(0, 64'h1028, 0, 8'h00, 64'h5a5a_0000_0000_1028, 0, 0, 0, 0);
        add_row(1, 64'h1028, 64'h1111_2222_3333_4444, 8'h0f, 0, 0, 0, 0, 0);
        add_row(0, 64'h1028, 0, 8'h00, 64'h5a5a_0000_3333_4444, 0, 0, 0, 0);
        // store miss into the free way
        add_row(1, 64'h2028, 64'haaaa_bbbb_cccc_dddd, 8'hf0, 0, 1, 0, 0, 0);
        add_row(0, 64'h2028, 0, 8'h00, 64'haaaa_bbbb_0000_2028, 0, 0, 0, 0);
        // third tag evicts the older dirty way, then the evicted lines come back
        add_row(0, 64'h3028, 0, 8'h00, 64'h5a5a_0000_0000_3028, 1, 1, 64'h1028,
                64'h5a5a_0000_3333_4444);
        add_row(0, 64'h1028, 0, 8'h00, 64'h5a5a_0000_3333_4444, 1, 1, 64'h2028,
                64'haaaa_bbbb_0000_2028);
        add_row(0, 64'h2028, 0, 8'h00, 64'haaaa_bbbb_0000_2028, 1, 0, 0, 0);
    endtask

    task automatic run_row(input int id, input row_t r, output logic late);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        @(posedge clk);
        #5;
        cpu_req.rd       = !r.wr;
        cpu_req.wr       = r.wr;
        cpu_req.addr.raw = r.addr;
        cpu_req.wdata    = r.wdata;
        cpu_req.mask     = r.mask;
        i_dcache_checker.start_test(id, r.wr, r.addr, r.rdata, r.miss, r.wb,
                                    r.wb_addr, r.wb_data);
        while (!seen && waited < done_timeout) begin
            @(negedge clk);
            waited++;
            seen = (cpu_rsp.done === 1'b1);
        end
        if (!seen)
            i_dcache_checker.report_problem($sformatf("no done within %0d cycles", waited));
        @(posedge clk);
        #5;
        cpu_req = '0;
        i_dcache_checker.finish_test();
        late = !seen;
    endtask

    task automatic finish_run();
        int errors;
        i_dcache_checker.print_summary(errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    initial begin
        rst       = 1'b0;
        cpu_req   = '0;
        mem_ok    = 1'b0;
        mem_rdata = '0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        seed      = 32'h4f15_ec17;
        timed_out = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b1;
        // quiet cycles after reset, watched by the checker
        repeat (3) @(posedge clk);
        foreach (rows[i]) begin
            if (!timed_out)
                run_row(i, rows[i], timed_out);
        end
        finish_run();
    end

endmodule

/* verilog.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_replace.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv
